// ==== vlog.f ====
design/synth_pkg.sv
design/voice_bus_if.sv
design/note_decoder.sv
design/adsr_envelope.sv
design/voice_oscillator.sv
design/voice_mixer.sv
design/pdm_modulator.sv
design/synth_top.sv
testbench/synth_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = synth_tb
FILELIST = vlog.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/synth_tb.sv ====
`timescale 1ns/1ps

module synth_tb;
   import synth_pkg::*;

   // short envelope so a release fits in a few dozen cycles
   localparam int   attack_cycles   = 64;
   localparam int   decay_cycles    = 32;
   localparam int   release_cycles  = 48;
   localparam env_t peak_level      = 16'h8000;
   localparam env_t sustain_level   = 16'h2000;
   // schedule lengths
   localparam int   reset_cycles    = 16;
   localparam int   random_patterns = 12;
   localparam int   gap_cycles      = 200;
   localparam int   solo_cycles     = 400;
   localparam int   tail_cycles     = 100;

   logic        clk_100mhz;
   logic        sys_rst;
   voice_mask_t keys;
   logic        spk;
   sample_t     audio_sample;
   voice_mask_t active_voices;

   // planned key patterns and their hold lengths
   voice_mask_t pattern_q [$];
   int          hold_q [$];
   int          solo_index;
   logic [31:0] rng_state;

   // run length and watchdog limit
   int          cycle_count;
   int          cycle_limit;
   // history counters the properties look at
   int          low_cnt [num_voices];
   int          zero_run;
   int          stable_cnt;
   voice_mask_t prev_keys = '0;
   int          spk_ones;

   // failures per behavior
   int err_reset;
   int err_press;
   int err_hold;
   int err_release;
   int err_silence;
   int err_level;
   int err_range;
   int err_spk;

   synth_top #(
      .ATTACK_CYCLES  (attack_cycles),
      .DECAY_CYCLES   (decay_cycles),
      .RELEASE_CYCLES (release_cycles),
      .PEAK_LEVEL     (peak_level),
      .SUSTAIN_LEVEL  (sustain_level)
   ) dut (
      .clk_100mhz    (clk_100mhz),
      .sys_rst       (sys_rst),
      .keys          (keys),
      .spk           (spk),
      .audio_sample  (audio_sample),
      .active_voices (active_voices)
   );

   initial begin
      clk_100mhz = 1'b0;
      forever #5 clk_100mhz = ~clk_100mhz;
   end

   // numerical recipes constants
   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // one random chord, held 20 to 300 cycles
   task automatic plan_random_pattern();
      voice_mask_t pattern;
      int          hold;
      rng_state = lcg_next(rng_state);
      pattern   = rng_state[23:16];
      rng_state = lcg_next(rng_state);
      hold      = 20 + int'(rng_state[31:8] % 32'd281);
      pattern_q.push_back(pattern);
      hold_q.push_back(hold);
   endtask

   // keys change on the falling edge, spk read there too
   task automatic play_step(input int idx);
      keys = pattern_q[idx];
      repeat (hold_q[idx]) begin
         @(negedge clk_100mhz);
         if (idx == solo_index && spk) begin
            spk_ones++;
         end
      end
   endtask

   // counters advance on the same edge the properties sample
   always @(posedge clk_100mhz) begin
      cycle_count <= cycle_count + 1;
      prev_keys   <= keys;
      stable_cnt  <= (keys == prev_keys) ? stable_cnt + 1 : 0;
      zero_run    <= (active_voices == '0) ? zero_run + 1 : 0;
      for (int v = 0; v < num_voices; v++) begin
         low_cnt[v] <= keys[v] ? 0 : low_cnt[v] + 1;
      end
   end

   // cleared outputs in reset and just after it
   assert property (@(posedge clk_100mhz)
      ($past(sys_rst) || $past(sys_rst, 2)) |->
         (!spk && audio_sample == '0 && active_voices == '0))
   else begin
      err_reset++;
      $display("Error at %0t: outputs not cleared around reset", $time);
   end

   for (genvar i = 0; i < num_voices; i++) begin : g_voice_checks
      // decoder plus oscillator, two cycles
      assert property (@(posedge clk_100mhz) disable iff (sys_rst)
         ($past(keys[i], 2) && !$past(keys[i], 3)) |-> active_voices[i])
      else begin
         err_press++;
         $display("Error at %0t: voice %0d not active 2 cycles after press", $time, i);
      end
      // a held key keeps its voice
      assert property (@(posedge clk_100mhz) disable iff (sys_rst)
         (keys[i] && $past(keys[i]) && $past(keys[i], 2)) |-> active_voices[i])
      else begin
         err_hold++;
         $display("Error at %0t: voice %0d dropped while its key is held", $time, i);
      end
      // release time plus a few cycles of slack
      assert property (@(posedge clk_100mhz) disable iff (sys_rst)
         (!keys[i] && low_cnt[i] > release_cycles + 4) |-> !active_voices[i])
      else begin
         err_release++;
         $display("Error at %0t: voice %0d still active after release", $time, i);
      end
   end

   // mixer pipeline drains once all voices are idle
   assert property (@(posedge clk_100mhz) disable iff (sys_rst)
      (zero_run >= 6 && active_voices == '0) |-> (audio_sample == '0 && !spk))
   else begin
      err_silence++;
      $display("Error at %0t: output not silent, sample %h", $time, $sampled(audio_sample));
   end

   // shaper never hits zero, so one sounding key is audible
   assert property (@(posedge clk_100mhz) disable iff (sys_rst)
      ($onehot(keys) && keys == prev_keys && stable_cnt > 8) |-> audio_sample != '0)
   else begin
      err_level++;
      $display("Error at %0t: sample is 0 with one key held", $time);
   end

   // at most 255/256 of full scale
   assert property (@(posedge clk_100mhz) disable iff (sys_rst)
      audio_sample <= 16'hff00)
   else begin
      err_range++;
      $display("Error at %0t: sample %h above 16'hff00", $time, $sampled(audio_sample));
   end

   // hang guard
   initial begin
      wait (cycle_limit != 0);
      wait (cycle_count >= cycle_limit);
      $display("Timeout: stimulus still running after %0d cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      int total_cycles;
      int total_errors;
      keys      = '0;
      sys_rst   = 1'b1;
      rng_state = 32'hdc6c;
      // whole schedule up front so the limit can be sized
      for (int n = 0; n < random_patterns; n++) begin
         plan_random_pattern();
      end
      // silence, then one key alone from an idle start
      pattern_q.push_back('0);
      hold_q.push_back(gap_cycles);
      solo_index = pattern_q.size();
      pattern_q.push_back(8'h10);
      hold_q.push_back(solo_cycles);
      for (int n = 0; n < random_patterns; n++) begin
         plan_random_pattern();
      end
      // let the last releases finish
      pattern_q.push_back('0);
      hold_q.push_back(tail_cycles);
      total_cycles = reset_cycles;
      foreach (hold_q[n]) begin
         total_cycles += hold_q[n];
      end
      cycle_limit = total_cycles * 3 / 2;

      repeat (reset_cycles) @(negedge clk_100mhz);
      sys_rst = 1'b0;
      for (int n = 0; n < pattern_q.size(); n++) begin
         play_step(n);
         if (n == solo_index) begin
            assert (spk_ones > 0)
            else begin
               err_spk++;
               $display("Error at %0t: spk never high during the single-key hold", $time);
            end
         end
      end

      total_errors = err_reset + err_press + err_hold + err_release + err_silence
                   + err_level + err_range + err_spk;
      $display("Errors: reset %0d press %0d hold %0d release %0d silence %0d %s %0d %s %0d %s %0d",
               err_reset, err_press, err_hold, err_release, err_silence,
               "level", err_level, "range", err_range, "spk", err_spk);
      if (total_errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== design/synth_top.sv ====
`timescale 1ns/1ps

module synth_top #(
   // times in 100 MHz cycles, 500 ms, 500 ms, 50 ms
   parameter int              ATTACK_CYCLES  = 50_000_000,
   parameter int              DECAY_CYCLES   = 50_000_000,
   parameter int              RELEASE_CYCLES = 5_000_000,
   parameter synth_pkg::env_t PEAK_LEVEL     = 16'h8888,
   parameter synth_pkg::env_t SUSTAIN_LEVEL  = 16'h0800
) (
   input  logic                   clk_100mhz,
   input  logic                   sys_rst,
   input  synth_pkg::voice_mask_t keys,
   output logic                   spk,
   output synth_pkg::sample_t     audio_sample,
   output synth_pkg::voice_mask_t active_voices
);
   import synth_pkg::*;

   voice_mask_t gate;
   voice_mask_t trigger;

   voice_bus_if bus ();

   // keys to gates and press strobes
   note_decoder u_decoder (
      .clk_100mhz (clk_100mhz),
      .sys_rst    (sys_rst),
      .keys       (keys),
      .gate       (gate),
      .trigger    (trigger)
   );

   // phases and envelopes onto the voice bus
   voice_oscillator #(
      .ATTACK_CYCLES  (ATTACK_CYCLES),
      .DECAY_CYCLES   (DECAY_CYCLES),
      .RELEASE_CYCLES (RELEASE_CYCLES),
      .PEAK_LEVEL     (PEAK_LEVEL),
      .SUSTAIN_LEVEL  (SUSTAIN_LEVEL)
   ) u_osc (
      .clk_100mhz (clk_100mhz),
      .sys_rst    (sys_rst),
      .gate       (gate),
      .trigger    (trigger),
      .bus        (bus.osc)
   );

   // five-stage mix down to one sample
   voice_mixer u_mixer (
      .clk_100mhz   (clk_100mhz),
      .sys_rst      (sys_rst),
      .bus          (bus.mix),
      .audio_sample (audio_sample)
   );

   // single speaker bit
   pdm_modulator #(
      .SAMPLE_WIDTH ($bits(sample_t))
   ) u_pdm (
      .clk_100mhz (clk_100mhz),
      .sys_rst    (sys_rst),
      .level      (audio_sample),
      .spk        (spk)
   );

   assign active_voices = bus.active;

endmodule

// ==== design/pdm_modulator.sv ====
`timescale 1ns/1ps

module pdm_modulator #(
   parameter int SAMPLE_WIDTH = 16
) (
   input  logic               clk_100mhz,
   input  logic               sys_rst,
   input  synth_pkg::sample_t level,
   output logic               spk
);

   logic [SAMPLE_WIDTH-1:0] acc;
   logic [SAMPLE_WIDTH:0]   acc_sum;

   // one extra bit catches the carry
   assign acc_sum = {1'b0, acc} + (SAMPLE_WIDTH + 1)'(level);

   // carry out is the density-coded bit
   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         acc <= '0;
         spk <= 1'b0;
      end else begin
         acc <= acc_sum[SAMPLE_WIDTH-1:0];
         spk <= acc_sum[SAMPLE_WIDTH];
      end
   end

endmodule

// ==== design/voice_mixer.sv ====
`timescale 1ns/1ps

module voice_mixer (
   input  logic               clk_100mhz,
   input  logic               sys_rst,
   voice_bus_if.mix           bus,
   output synth_pkg::sample_t audio_sample
);
   import synth_pkg::*;

   // stage 1 outputs
   sample_t     shaped [num_voices];
   env_t        env_d [num_voices];
   voice_mask_t act_d;
   // stage 2 to 4 outputs
   sample_t     scaled [num_voices];
   logic [16:0] pair_sum [num_voices/2];
   logic [18:0] total;
   // count is already one cycle late on the bus
   voice_count_t count_d [3];
   logic [31:0] full_prod [num_voices];
   logic [26:0] norm_prod;

   // parabola per half-wave around mid-scale
   // swing of a quarter scale keeps the output off zero
   function automatic sample_t shape_sine(input wave_addr_t addr);
      logic [6:0]  x;
      logic [13:0] p;
      logic [15:0] offset;
      x      = addr[6:0];
      // x*(128-x), peak 4096 at x=64
      p      = 14'(x) * 14'(8'd128 - {1'b0, x});
      offset = {p, 2'b00};
      return addr[7] ? 16'h8000 - offset : 16'h8000 + offset;
   endfunction

   always_comb begin
      for (int v = 0; v < num_voices; v++) begin
         full_prod[v] = shaped[v] * env_d[v];
      end
      norm_prod = total * mix_recip[count_d[2]];
   end

   // shaping, scaling and adder tree
   always_ff @(posedge clk_100mhz) begin
      for (int v = 0; v < num_voices; v++) begin
         // stage 1 shaping, envelope delayed to match
         shaped[v] <= shape_sine(bus.phase_addr[v]);
         env_d[v]  <= bus.envelope[v];
         // stage 2 envelope scaling, silent voices give 0
         scaled[v] <= act_d[v] ? full_prod[v][31:16] : '0;
      end
      // stage 3 pairs
      for (int j = 0; j < num_voices / 2; j++) begin
         pair_sum[j] <= scaled[2*j] + scaled[2*j+1];
      end
      // stage 4 full sum
      total <= pair_sum[0] + pair_sum[1] + pair_sum[2] + pair_sum[3];
   end

   // activity, count and the output register
   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         act_d        <= '0;
         count_d      <= '{default: '0};
         audio_sample <= '0;
      end else begin
         act_d      <= bus.active;
         count_d[0] <= bus.active_count;
         count_d[1] <= count_d[0];
         count_d[2] <= count_d[1];
         // stage 5 divide by voice count, at most 255/256
         audio_sample <= norm_prod[23:8];
      end
   end

endmodule

// ==== design/voice_oscillator.sv ====
`timescale 1ns/1ps

module voice_oscillator #(
   parameter int              ATTACK_CYCLES  = 64,
   parameter int              DECAY_CYCLES   = 32,
   parameter int              RELEASE_CYCLES = 48,
   parameter synth_pkg::env_t PEAK_LEVEL     = 16'h8000,
   parameter synth_pkg::env_t SUSTAIN_LEVEL  = 16'h2000
) (
   input  logic                   clk_100mhz,
   input  logic                   sys_rst,
   input  synth_pkg::voice_mask_t gate,
   input  synth_pkg::voice_mask_t trigger,
   voice_bus_if.osc               bus
);
   import synth_pkg::*;

   phase_t      phase [num_voices];
   env_t        env_level [num_voices];
   voice_mask_t env_active;

   // one envelope per voice
   for (genvar i = 0; i < num_voices; i++) begin : g_voice
      adsr_envelope #(
         .ATTACK_CYCLES  (ATTACK_CYCLES),
         .DECAY_CYCLES   (DECAY_CYCLES),
         .RELEASE_CYCLES (RELEASE_CYCLES),
         .PEAK_LEVEL     (PEAK_LEVEL),
         .SUSTAIN_LEVEL  (SUSTAIN_LEVEL)
      ) u_env (
         .clk_100mhz (clk_100mhz),
         .sys_rst    (sys_rst),
         .gate       (gate[i]),
         .trigger    (trigger[i]),
         .envelope   (env_level[i]),
         .active     (env_active[i])
      );

      // top bits address the waveform
      assign bus.phase_addr[i] = phase[i][31:24];
      assign bus.envelope[i]   = env_level[i];
   end

   // accumulators run only while the voice sounds
   // idle voices restart from phase zero
   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         for (int v = 0; v < num_voices; v++) begin
            phase[v] <= '0;
         end
         bus.active_count <= '0;
      end else begin
         for (int v = 0; v < num_voices; v++) begin
            phase[v] <= env_active[v] ? phase[v] + tuning_words[v] : '0;
         end
         // lags active by one cycle, mixer accounts for it
         bus.active_count <= voice_count_t'($countones(env_active));
      end
   end

   assign bus.active = env_active;

endmodule

// ==== design/adsr_envelope.sv ====
`timescale 1ns/1ps

module adsr_envelope #(
   parameter int              ATTACK_CYCLES  = 64,
   parameter int              DECAY_CYCLES   = 32,
   parameter int              RELEASE_CYCLES = 48,
   parameter synth_pkg::env_t PEAK_LEVEL     = 16'h8000,
   parameter synth_pkg::env_t SUSTAIN_LEVEL  = 16'h2000
) (
   input  logic            clk_100mhz,
   input  logic            sys_rst,
   input  logic            gate,
   input  logic            trigger,
   output synth_pkg::env_t envelope,
   output logic            active
);
   import synth_pkg::*;

   // levels in 16.16 fixed point, wide copies for the step math
   localparam logic [47:0] peak_wide = {16'h0, PEAK_LEVEL, 16'h0};
   localparam logic [47:0] sus_wide  = {16'h0, SUSTAIN_LEVEL, 16'h0};
   localparam logic [31:0] peak_fx   = peak_wide[31:0];
   localparam logic [31:0] sus_fx    = sus_wide[31:0];

   // per-cycle steps, rounded up so each phase ends in time
   localparam logic [31:0] attack_step =
      32'((peak_wide + 48'(ATTACK_CYCLES - 1)) / 48'(ATTACK_CYCLES));
   localparam logic [31:0] decay_step =
      32'((peak_wide - sus_wide + 48'(DECAY_CYCLES - 1)) / 48'(DECAY_CYCLES));
   // sized from the peak so release from any level fits
   localparam logic [31:0] release_step =
      32'((peak_wide + 48'(RELEASE_CYCLES - 1)) / 48'(RELEASE_CYCLES));

   adsr_state_t state;
   logic [31:0] level_fx;

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         state    <= adsr_idle;
         level_fx <= '0;
      end else if (trigger) begin
         // restart from wherever the level is
         state <= adsr_attack;
      end else begin
         case (state)
            adsr_idle: begin
               level_fx <= '0;
            end
            adsr_attack: begin
               if (!gate) begin
                  state <= adsr_release;
               end else if ((peak_fx - level_fx) <= attack_step) begin
                  // clamp at peak
                  level_fx <= peak_fx;
                  state    <= adsr_decay;
               end else begin
                  level_fx <= level_fx + attack_step;
               end
            end
            adsr_decay: begin
               if (!gate) begin
                  state <= adsr_release;
               end else if ((level_fx - sus_fx) <= decay_step) begin
                  level_fx <= sus_fx;
                  state    <= adsr_sustain;
               end else begin
                  level_fx <= level_fx - decay_step;
               end
            end
            adsr_sustain: begin
               level_fx <= sus_fx;
               if (!gate) begin
                  state <= adsr_release;
               end
            end
            adsr_release: begin
               // last step lands on zero
               if (level_fx <= release_step) begin
                  level_fx <= '0;
                  state    <= adsr_idle;
               end else begin
                  level_fx <= level_fx - release_step;
               end
            end
            default: begin
               state <= adsr_idle;
            end
         endcase
      end
   end

   // integer part only
   assign envelope = level_fx[31:16];
   assign active   = (state != adsr_idle);

endmodule

// ==== design/note_decoder.sv ====
`timescale 1ns/1ps

module note_decoder (
   input  logic                   clk_100mhz,
   input  logic                   sys_rst,
   input  synth_pkg::voice_mask_t keys,
   output synth_pkg::voice_mask_t gate,
   output synth_pkg::voice_mask_t trigger
);

   // gate is the key level one cycle late
   // trigger marks the cycle where a gate bit goes high
   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         gate    <= '0;
         trigger <= '0;
      end else begin
         gate <= keys;
         // gate still holds the old level here
         trigger <= keys & ~gate;
      end
   end

endmodule

// ==== design/voice_bus_if.sv ====
`timescale 1ns/1ps

interface voice_bus_if;
   import synth_pkg::*;

   // waveform address per voice, top phase bits
   wave_addr_t phase_addr [num_voices];
   // envelope level per voice
   env_t envelope [num_voices];
   // one bit per sounding voice
   voice_mask_t active;
   // popcount of active, one cycle behind it
   voice_count_t active_count;

   modport osc (
      output phase_addr, envelope, active, active_count
   );

   modport mix (
      input phase_addr, envelope, active, active_count
   );

endinterface

// ==== design/synth_pkg.sv ====
package synth_pkg;

   // voice and key count
   localparam int num_voices = 8;

   // audio and control widths
   typedef logic [15:0] sample_t;
   typedef logic [15:0] env_t;
   typedef logic [31:0] phase_t;
   typedef logic [7:0] wave_addr_t;
   typedef logic [num_voices-1:0] voice_mask_t;
   typedef logic [$clog2(num_voices+1)-1:0] voice_count_t;

   // envelope phases
   typedef enum logic [2:0] {
      adsr_idle,
      adsr_attack,
      adsr_decay,
      adsr_sustain,
      adsr_release
   } adsr_state_t;

   // phase increments, f * 2^32 / 100 MHz
   // c4 d4 e4 f4 g4 a4 b4 c5
   localparam phase_t tuning_words [0:num_voices-1] = '{
      32'd11237,
      32'd12613,
      32'd14157,
      32'd14999,
      32'd16836,
      32'd18898,
      32'd21212,
      32'd22474
   };

   // 256/n, indexed by active voice count
   localparam logic [7:0] mix_recip [0:num_voices] = '{
      8'd0, 8'd255, 8'd128, 8'd85, 8'd64, 8'd51, 8'd42, 8'd36, 8'd32
   };

endpackage
